//--- pkt_buf_pkg.sv
package pkt_buf_pkg;

    // Data path.
    localparam int word_w = 16;
    localparam int page_words = 8;
    localparam int word_idx_w = 3;
    localparam int ecc_w = 8;

    // Header length field, bits 15..7.
    localparam int len_w = 9;

    // Head and tail addresses carry the bank number above the page number.
    localparam int addr_w = 16;
    localparam int bank_w = 5;

    // Output stamp is one bit wider than the input stamp.
    localparam int ts_w = 6;
    localparam logic [ts_w-1:0] ts_invalid = 6'd32;

    typedef enum logic [1:0] {
        wr_idle,
        wr_first_page,
        wr_next_pages
    } wr_state_e;

endpackage

//--- page_sram.sv
`timescale 1ns/1ps

module page_sram #(
    parameter int page_count = 2048,
    localparam int sw = $clog2(page_count) + pkt_buf_pkg::word_idx_w
) (
    input  logic                           clk,
    input  logic                           we,
    input  logic [sw-1:0]                  wr_addr,
    input  logic [pkt_buf_pkg::word_w-1:0] din,
    input  logic [sw-1:0]                  rd_addr,
    output logic [pkt_buf_pkg::word_w-1:0] dout
);

    // Address is {page, word index}.
    logic [pkt_buf_pkg::word_w-1:0] mem [page_count * pkt_buf_pkg::page_words];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= din;
        end
    end

    // Registered read, one cycle of latency.
    always_ff @(posedge clk) begin
        dout <= mem[rd_addr];
    end

endmodule

//--- free_page_queue.sv
`timescale 1ns/1ps

module free_page_queue #(
    parameter int page_count = 2048,
    localparam int aw = $clog2(page_count)
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          page_taken,
    input  logic                          lookahead_req,
    input  logic [pkt_buf_pkg::len_w-1:0] lookahead_words,
    output logic [aw-1:0]                 next_page,
    output logic [aw-1:0]                 tail_page,
    output logic                          ready
);

    // Page 0 is handed to the writer directly, so the queue holds one page less.
    localparam logic [aw-1:0] last_slot = aw'(page_count - 2);

    logic [aw-1:0] mem [page_count];
    logic [aw-1:0] head_ptr;
    logic [aw-1:0] tail_ptr;
    logic [aw-1:0] head_next;
    logic [aw-1:0] ahead_ptr;
    logic [pkt_buf_pkg::len_w-3:0] la_pages;

    always_comb begin
        head_next = page_taken ? head_ptr + 1'b1 : head_ptr;
        // Pages in the packet, rounded up.
        la_pages = {1'b0, lookahead_words[pkt_buf_pkg::len_w-1:3]} + (|lookahead_words[2:0]);
        // The writer already owns the first page, so the tail sits pages - 2 past head.
        ahead_ptr = head_ptr + aw'(la_pages) - aw'(2);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_ptr <= '0;
        end else begin
            head_ptr <= head_next;
        end
    end

    // Self fill after reset, one page number per cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tail_ptr <= '0;
            ready <= 1'b0;
        end else if (!ready) begin
            tail_ptr <= tail_ptr + 1'b1;
            if (tail_ptr == last_slot) begin
                ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ready) begin
            mem[tail_ptr] <= tail_ptr + 1'b1;
        end
    end

    // Reading at head_next keeps next_page current right after a page is taken.
    always_ff @(posedge clk) begin
        next_page <= mem[head_next];
    end

    // Tail prediction, held until the next header.
    always_ff @(posedge clk) begin
        if (lookahead_req) begin
            tail_page <= mem[ahead_ptr];
        end
    end

endmodule

//--- page_link_table.sv
`timescale 1ns/1ps

module page_link_table #(
    parameter int page_count = 2048,
    localparam int aw = $clog2(page_count)
) (
    input  logic                           clk,
    input  logic                           link_we,
    input  logic [aw-1:0]                  link_page,
    input  logic [aw-1:0]                  link_next,
    input  logic                           concat_en,
    input  logic [pkt_buf_pkg::addr_w-1:0] concat_head,
    input  logic [pkt_buf_pkg::addr_w-1:0] concat_tail,
    input  logic [aw-1:0]                  rd_page,
    output logic [aw-1:0]                  rd_link
);

    logic [aw-1:0] mem [page_count];

    // Concatenation wins over the writer.
    // Only the page field of the scheduler's addresses is stored.
    always_ff @(posedge clk) begin
        if (concat_en) begin
            mem[concat_head[aw-1:0]] <= concat_tail[aw-1:0];
        end else if (link_we) begin
            mem[link_page] <= link_next;
        end
    end

    always_ff @(posedge clk) begin
        rd_link <= mem[rd_page];
    end

endmodule

//--- page_ecc_store.sv
`timescale 1ns/1ps

module page_ecc_store #(
    parameter int page_count = 2048,
    localparam int aw = $clog2(page_count)
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               word_strobe,
    input  logic [pkt_buf_pkg::word_idx_w-1:0] word_index,
    input  logic [pkt_buf_pkg::word_w-1:0]     word,
    input  logic                               page_end,
    input  logic [aw-1:0]                      page,
    input  logic [aw-1:0]                      rd_page,
    output logic [pkt_buf_pkg::ecc_w-1:0]      rd_ecc
);

    logic [pkt_buf_pkg::word_w-1:0] word_buf [pkt_buf_pkg::page_words];
    logic [pkt_buf_pkg::ecc_w-1:0]  code_mem [page_count];
    logic                           pend;
    logic [aw-1:0]                  pend_page;
    logic [pkt_buf_pkg::word_w-1:0] fold;
    logic [pkt_buf_pkg::ecc_w-1:0]  code;

    // Word 0 clears the rest, so a short page codes its missing words as zero.
    always_ff @(posedge clk) begin
        if (word_strobe) begin
            if (word_index == '0) begin
                for (int i = 1; i < pkt_buf_pkg::page_words; i++) begin
                    word_buf[i] <= '0;
                end
            end
            word_buf[word_index] <= word;
        end
    end

    // Column parity: fold all words, then fold the two bytes.
    always_comb begin
        fold = '0;
        for (int i = 0; i < pkt_buf_pkg::page_words; i++) begin
            fold = fold ^ word_buf[i];
        end
        code = fold[pkt_buf_pkg::ecc_w-1:0] ^ fold[pkt_buf_pkg::word_w-1:pkt_buf_pkg::ecc_w];
    end

    // The last word lands in the buffer at the page end, so the code is written a cycle later.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend <= 1'b0;
        end else begin
            pend <= page_end;
        end
    end

    always_ff @(posedge clk) begin
        if (page_end) begin
            pend_page <= page;
        end
    end

    always_ff @(posedge clk) begin
        if (pend) begin
            code_mem[pend_page] <= code;
        end
    end

    always_ff @(posedge clk) begin
        rd_ecc <= code_mem[rd_page];
    end

endmodule

//--- packet_writer.sv
`timescale 1ns/1ps

module packet_writer #(
    parameter int page_count = 2048,
    parameter logic [pkt_buf_pkg::bank_w-1:0] bank_index = '0,
    localparam int aw = $clog2(page_count)
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  wr_data_vld,
    input  logic [pkt_buf_pkg::word_w-1:0]        wr_data,
    input  logic                                  wr_end_of_packet,
    input  logic [pkt_buf_pkg::ts_w-2:0]          time_stamp,
    input  logic [aw-1:0]                         next_page,
    input  logic [aw-1:0]                         tail_page,
    output logic                                  sram_we,
    output logic [aw+pkt_buf_pkg::word_idx_w-1:0] sram_addr,
    output logic [pkt_buf_pkg::word_w-1:0]        sram_din,
    output logic                                  page_taken,
    output logic                                  lookahead_req,
    output logic [pkt_buf_pkg::len_w-1:0]         lookahead_words,
    output logic                                  link_we,
    output logic [aw-1:0]                         link_page,
    output logic [aw-1:0]                         link_next,
    output logic                                  word_strobe,
    output logic [pkt_buf_pkg::word_idx_w-1:0]    word_index,
    output logic                                  page_end,
    output logic [3:0]                            dest_port,
    output logic [2:0]                            prior,
    output logic [pkt_buf_pkg::addr_w-1:0]        head_addr,
    output logic [pkt_buf_pkg::addr_w-1:0]        tail_addr,
    output logic                                  cat_request,
    output logic [pkt_buf_pkg::ts_w-1:0]          packet_time_stamp
);

    localparam int page_f_w = pkt_buf_pkg::addr_w - pkt_buf_pkg::bank_w;
    localparam int stamp_w = pkt_buf_pkg::ts_w - 1;

    pkt_buf_pkg::wr_state_e wr_state;
    logic [pkt_buf_pkg::word_idx_w-1:0] word_idx;
    logic [aw-1:0] cur_page;
    logic hdr;
    logic eop;
    logic single_q;
    logic tail_cap;

    assign hdr = (wr_state == pkt_buf_pkg::wr_idle) && wr_data_vld;
    assign eop = wr_data_vld && wr_end_of_packet;
    assign page_end = wr_data_vld &&
                      (word_idx == pkt_buf_pkg::word_idx_w'(pkt_buf_pkg::page_words - 1) ||
                       wr_end_of_packet);

    assign sram_we = wr_data_vld;
    assign sram_addr = {cur_page, word_idx};
    assign sram_din = wr_data;
    assign page_taken = page_end;
    assign link_we = page_end;
    assign link_page = cur_page;
    assign link_next = next_page;
    assign word_strobe = wr_data_vld;
    assign word_index = word_idx;
    assign lookahead_req = hdr;
    assign lookahead_words = wr_data[15:7];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= pkt_buf_pkg::wr_idle;
        end else begin
            case (wr_state)
                pkt_buf_pkg::wr_idle: begin
                    // A one word packet never leaves idle.
                    if (wr_data_vld && !wr_end_of_packet) begin
                        wr_state <= pkt_buf_pkg::wr_first_page;
                    end
                end
                pkt_buf_pkg::wr_first_page: begin
                    if (eop) begin
                        wr_state <= pkt_buf_pkg::wr_idle;
                    end else if (page_end) begin
                        wr_state <= pkt_buf_pkg::wr_next_pages;
                    end
                end
                pkt_buf_pkg::wr_next_pages: begin
                    if (eop) begin
                        wr_state <= pkt_buf_pkg::wr_idle;
                    end
                end
                default: wr_state <= pkt_buf_pkg::wr_idle;
            endcase
        end
    end

    // Word index and current page advance together at a page end.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_idx <= '0;
            cur_page <= '0;
        end else if (page_end) begin
            word_idx <= '0;
            cur_page <= next_page;
        end else if (wr_data_vld) begin
            word_idx <= word_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr) begin
            dest_port <= wr_data[3:0];
            prior <= wr_data[6:4];
            head_addr <= {bank_index, page_f_w'(cur_page)};
            single_q <= (wr_data[15:7] <= pkt_buf_pkg::len_w'(pkt_buf_pkg::page_words));
        end
        // Queue look-ahead is ready a cycle after the header.
        if (tail_cap) begin
            tail_addr <= single_q ? head_addr : {bank_index, page_f_w'(tail_page)};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cat_request <= 1'b0;
            tail_cap <= 1'b0;
        end else begin
            cat_request <= hdr;
            tail_cap <= cat_request;
        end
    end

    // Stamp expires one tick before the free running counter wraps back to it.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            packet_time_stamp <= pkt_buf_pkg::ts_invalid;
        end else if (hdr) begin
            packet_time_stamp <= {1'b0, time_stamp};
        end else if (!packet_time_stamp[stamp_w] &&
                     stamp_w'(time_stamp + 1'b1) == packet_time_stamp[stamp_w-1:0]) begin
            packet_time_stamp <= pkt_buf_pkg::ts_invalid;
        end
    end

endmodule

//--- packet_buffer.sv
`timescale 1ns/1ps

module packet_buffer #(
    parameter int page_count = 2048,
    parameter logic [pkt_buf_pkg::bank_w-1:0] bank_index = '0,
    localparam int aw = $clog2(page_count)
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  wr_data_vld,
    input  logic [pkt_buf_pkg::word_w-1:0]        wr_data,
    input  logic                                  wr_end_of_packet,
    input  logic [pkt_buf_pkg::ts_w-2:0]          time_stamp,
    input  logic                                  concat_en,
    input  logic [pkt_buf_pkg::addr_w-1:0]        concat_head,
    input  logic [pkt_buf_pkg::addr_w-1:0]        concat_tail,
    input  logic                                  rd_en,
    input  logic [aw+pkt_buf_pkg::word_idx_w-1:0] rd_addr,
    output logic                                  queue_ready,
    output logic [3:0]                            dest_port,
    output logic [2:0]                            prior,
    output logic [pkt_buf_pkg::addr_w-1:0]        head_addr,
    output logic [pkt_buf_pkg::addr_w-1:0]        tail_addr,
    output logic                                  cat_request,
    output logic [pkt_buf_pkg::ts_w-1:0]          packet_time_stamp,
    output logic                                  rd_valid,
    output logic [pkt_buf_pkg::word_w-1:0]        rd_data,
    output logic [pkt_buf_pkg::ecc_w-1:0]         rd_ecc,
    output logic [aw-1:0]                         rd_link
);

    logic sram_we;
    logic [aw+pkt_buf_pkg::word_idx_w-1:0] sram_addr;
    logic [pkt_buf_pkg::word_w-1:0] sram_din;
    logic page_taken;
    logic lookahead_req;
    logic [pkt_buf_pkg::len_w-1:0] lookahead_words;
    logic link_we;
    logic [aw-1:0] link_page;
    logic [aw-1:0] link_next;
    logic word_strobe;
    logic [pkt_buf_pkg::word_idx_w-1:0] word_index;
    logic page_end;
    logic [aw-1:0] next_page;
    logic [aw-1:0] tail_page;
    logic [aw-1:0] rd_page;
    logic [pkt_buf_pkg::word_idx_w-1:0] rd_word;

    assign rd_page = rd_addr[aw+pkt_buf_pkg::word_idx_w-1:pkt_buf_pkg::word_idx_w];
    assign rd_word = rd_addr[pkt_buf_pkg::word_idx_w-1:0];

    // All read memories have one cycle of latency.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    packet_writer #(.page_count(page_count), .bank_index(bank_index)) u_writer (
        .clk(clk), .rst_n(rst_n),
        .wr_data_vld(wr_data_vld), .wr_data(wr_data),
        .wr_end_of_packet(wr_end_of_packet), .time_stamp(time_stamp),
        .next_page(next_page), .tail_page(tail_page),
        .sram_we(sram_we), .sram_addr(sram_addr), .sram_din(sram_din),
        .page_taken(page_taken), .lookahead_req(lookahead_req),
        .lookahead_words(lookahead_words),
        .link_we(link_we), .link_page(link_page), .link_next(link_next),
        .word_strobe(word_strobe), .word_index(word_index), .page_end(page_end),
        .dest_port(dest_port), .prior(prior), .head_addr(head_addr),
        .tail_addr(tail_addr), .cat_request(cat_request),
        .packet_time_stamp(packet_time_stamp)
    );

    free_page_queue #(.page_count(page_count)) u_free_queue (
        .clk(clk), .rst_n(rst_n),
        .page_taken(page_taken), .lookahead_req(lookahead_req),
        .lookahead_words(lookahead_words),
        .next_page(next_page), .tail_page(tail_page), .ready(queue_ready)
    );

    page_sram #(.page_count(page_count)) u_sram (
        .clk(clk), .we(sram_we), .wr_addr(sram_addr), .din(sram_din),
        .rd_addr({rd_page, rd_word}), .dout(rd_data)
    );

    page_link_table #(.page_count(page_count)) u_link_table (
        .clk(clk),
        .link_we(link_we), .link_page(link_page), .link_next(link_next),
        .concat_en(concat_en), .concat_head(concat_head), .concat_tail(concat_tail),
        .rd_page(rd_page), .rd_link(rd_link)
    );

    // The writer's link page is the page being filled.
    page_ecc_store #(.page_count(page_count)) u_ecc_store (
        .clk(clk), .rst_n(rst_n),
        .word_strobe(word_strobe), .word_index(word_index), .word(sram_din),
        .page_end(page_end), .page(link_page),
        .rd_page(rd_page), .rd_ecc(rd_ecc)
    );

endmodule

//--- tb_packet_buffer.sv
`timescale 1ns/1ps

module tb_packet_buffer;

    localparam int page_count = 64;
    localparam logic [4:0] bank = 5'd9;
    localparam int num_pkts = 10;
    localparam int max_len = 40;
    localparam logic [5:0] stamp_none = 6'd32;
    // Allows for the queue fill, every packet with its gap and two cycles per word read.
    localparam int cycle_limit = 4 + page_count + num_pkts * (max_len + 6)
                                 + num_pkts * max_len * 2 + 200;

    logic clk = 1'b0;
    logic rst_n;
    logic wr_data_vld;
    logic [15:0] wr_data;
    logic wr_end_of_packet;
    logic [4:0] time_stamp;
    logic concat_en;
    logic [15:0] concat_head;
    logic [15:0] concat_tail;
    logic rd_en;
    logic [8:0] rd_addr;
    logic queue_ready;
    logic [3:0] dest_port;
    logic [2:0] prior;
    logic [15:0] head_addr;
    logic [15:0] tail_addr;
    logic cat_request;
    logic [5:0] packet_time_stamp;
    logic rd_valid;
    logic [15:0] rd_data;
    logic [7:0] rd_ecc;
    logic [5:0] rd_link;

    logic hdr_flag;
    logic [31:0] rng;
    int errors;
    int checks;
    int cycle;
    int expiries;
    bit expiry_due;
    bit ready_seen;
    logic exp_cat;
    logic [5:0] exp_stamp;
    int model_page;
    logic [15:0] model_words [page_count * 8];
    int fill [page_count];
    int link_exp [page_count];
    bit link_known [page_count];
    int pkt_first [num_pkts];
    logic [3:0] dest_q [$];
    logic [2:0] prior_q [$];
    logic [15:0] head_q [$];

    packet_buffer #(.page_count(page_count), .bank_index(bank)) dut0 (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        time_stamp <= time_stamp + 1'b1;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int pages_for(input int len);
        return (len + 7) / 8;
    endfunction

    function automatic logic [15:0] make_addr(input int page);
        return {bank, 11'(page)};
    endfunction

    // Bit k is the parity of bits k and k+8 over all eight words of the page.
    function automatic logic [7:0] column_parity(input int page);
        logic [7:0] code;
        code = '0;
        for (int i = 0; i < 8; i++) begin
            code = code ^ model_words[page * 8 + i][7:0] ^ model_words[page * 8 + i][15:8];
        end
        return code;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Outputs are compared on the falling edge, then the models step on the inputs
    // that the DUT takes at the next rising edge.
    always @(negedge clk) begin
        if (rst_n) begin
            compare_value("cat_request", 32'(exp_cat), 32'(cat_request));
            compare_value("packet_time_stamp", 32'(exp_stamp), 32'(packet_time_stamp));
            if (expiry_due && packet_time_stamp === stamp_none) begin
                expiries++;
            end
            if (cat_request && head_q.size() > 0) begin
                compare_value("dest_port", 32'(dest_q.pop_front()), 32'(dest_port));
                compare_value("prior", 32'(prior_q.pop_front()), 32'(prior));
                compare_value("head_addr", 32'(head_q.pop_front()), 32'(head_addr));
            end
            if (ready_seen) begin
                compare_value("queue_ready held", 32'd1, 32'(queue_ready));
            end
        end
        exp_cat = rst_n && hdr_flag;
        expiry_due = 1'b0;
        if (!rst_n) begin
            exp_stamp = stamp_none;
        end else if (hdr_flag) begin
            exp_stamp = {1'b0, time_stamp};
        end else if (exp_stamp != stamp_none && time_stamp == 5'(exp_stamp[4:0] - 1'b1)) begin
            exp_stamp = stamp_none;
            expiry_due = 1'b1;
        end
    end

    task automatic send_packet(input int len);
        logic [15:0] word;
        logic [3:0] dest;
        logic [2:0] pri;
        int first;
        int pages;
        int page;
        rng = xorshift32(rng);
        dest = rng[3:0];
        pri = rng[6:4];
        first = model_page;
        pages = pages_for(len);
        dest_q.push_back(dest);
        prior_q.push_back(pri);
        head_q.push_back(make_addr(first));
        for (int w = 0; w < len; w++) begin
            if (w == 0) begin
                word = {9'(len), pri, dest};
            end else begin
                rng = xorshift32(rng);
                word = rng[15:0];
            end
            page = first + w / 8;
            model_words[page * 8 + w % 8] = word;
            fill[page] = w % 8 + 1;
            @(posedge clk);
            wr_data_vld <= 1'b1;
            wr_data <= word;
            wr_end_of_packet <= (w == len - 1);
            hdr_flag <= (w == 0);
        end
        @(posedge clk);
        wr_data_vld <= 1'b0;
        wr_end_of_packet <= 1'b0;
        hdr_flag <= 1'b0;
        for (int p = first; p < first + pages - 1; p++) begin
            link_exp[p] = p + 1;
            link_known[p] = 1'b1;
        end
        model_page = model_page + pages;
        // Tail prediction settles on the third cycle after the header.
        repeat (3) @(posedge clk);
        @(negedge clk);
        compare_value("tail_addr", 32'(make_addr(first + pages - 1)), 32'(tail_addr));
    endtask

    task automatic concat_link(input int head_page, input int tail_page);
        @(posedge clk);
        concat_en <= 1'b1;
        concat_head <= make_addr(head_page);
        concat_tail <= make_addr(tail_page);
        @(posedge clk);
        concat_en <= 1'b0;
        link_exp[head_page] = tail_page;
        link_known[head_page] = 1'b1;
    endtask

    task automatic read_word(input int page, input int idx);
        @(posedge clk);
        rd_en <= 1'b1;
        rd_addr <= {6'(page), 3'(idx)};
        @(negedge clk);
        compare_value("rd_valid idle", 32'd0, 32'(rd_valid));
        @(posedge clk);
        rd_en <= 1'b0;
        @(negedge clk);
        compare_value("rd_valid", 32'd1, 32'(rd_valid));
        compare_value($sformatf("rd_data p%0d w%0d", page, idx),
                      32'(model_words[page * 8 + idx]), 32'(rd_data));
        compare_value($sformatf("rd_ecc p%0d", page), 32'(column_parity(page)), 32'(rd_ecc));
        if (link_known[page]) begin
            compare_value($sformatf("rd_link p%0d", page), 32'(link_exp[page]), 32'(rd_link));
        end
    endtask

    initial begin
        int len;
        int waited;
        rng = 32'd19;
        errors = 0;
        checks = 0;
        cycle = 0;
        expiries = 0;
        expiry_due = 1'b0;
        model_page = 0;
        ready_seen = 1'b0;
        exp_cat = 1'b0;
        exp_stamp = stamp_none;
        rst_n = 1'b0;
        wr_data_vld = 1'b0;
        wr_data = '0;
        wr_end_of_packet = 1'b0;
        time_stamp = '0;
        concat_en = 1'b0;
        concat_head = '0;
        concat_tail = '0;
        rd_en = 1'b0;
        rd_addr = '0;
        hdr_flag = 1'b0;
        for (int i = 0; i < page_count * 8; i++) begin
            model_words[i] = '0;
        end
        for (int p = 0; p < page_count; p++) begin
            fill[p] = 0;
            link_known[p] = 1'b0;
        end

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // The free queue fills itself before any packet is sent.
        waited = 0;
        @(negedge clk);
        while (!queue_ready && waited < page_count) begin
            @(negedge clk);
            waited++;
        end
        if (queue_ready) begin
            ready_seen = 1'b1;
        end else begin
            errors++;
            $display("queue_ready did not rise within %0d cycles of reset", page_count);
        end

        // One word, a full page and one word past a page come before the random lengths.
        for (int k = 0; k < num_pkts; k++) begin
            if (k == 0) begin
                len = 1;
            end else if (k == 1) begin
                len = 8;
            end else if (k == 2) begin
                len = 9;
            end else begin
                rng = xorshift32(rng);
                len = 1 + int'(rng % 32'(max_len));
            end
            pkt_first[k] = model_page;
            send_packet(len);
        end

        concat_link(pkt_first[2], pkt_first[num_pkts - 1]);
        concat_link(pkt_first[0], pkt_first[5]);

        for (int p = 0; p < model_page; p++) begin
            for (int i = 0; i < fill[p]; i++) begin
                read_word(p, i);
            end
        end

        repeat (40) @(posedge clk);
        @(negedge clk);
        compare_value("stamp after expiry", 32'(stamp_none), 32'(packet_time_stamp));
        compare_value("stamp expiry seen", 32'd1, 32'(expiries > 0));

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- project.f
pkt_buf_pkg.sv
page_sram.sv
free_page_queue.sv
page_link_table.sv
page_ecc_store.sv
packet_writer.sv
packet_buffer.sv
tb_packet_buffer.sv

//--- Makefile
TOP = tb_packet_buffer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f project.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' sim.log

clean:
	rm -rf obj_dir sim.log
